//--- build.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module sensor_bridge_tb \
   -f sensor_bridge.f -o sensor_bridge_sim &&
./obj_dir/sensor_bridge_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- include/sensor_bridge_settings.svh
`ifndef SENSOR_BRIDGE_SETTINGS_SVH
`define SENSOR_BRIDGE_SETTINGS_SVH

// bytes per FIFO as a power of two
`define FIFO_DEPTH 16

// clocks per PWM count step
`define PWM_PRESCALE 4

// shutter servo counts where the pulse stays high through count == duty
`define SHUTTER_OPEN_DUTY 80
`define SHUTTER_CLOSED_DUTY 150

// one shutter pulse every this many PWM periods
`define SHUTTER_FRAME_PERIODS 4

// clocks per half period of the MCP3008 dclk
`define ADC_DCLK_DIV 4

`endif

//--- rtl/byte_fifo.sv
`default_nettype none
`timescale 1ns/100ps

// first-word-fall-through with the head visible on rdata while not empty
module byte_fifo #(
   parameter int depth = 16
) (
   input wire          clk,
   input wire          arst_n,
   fifo_port_if.storage q
);

   localparam int aw = $clog2(depth);

   logic [7:0]  mem [depth];
   logic [aw:0] wptr;   // extra msb tells full from empty
   logic [aw:0] rptr;

   assign q.rempty = (wptr == rptr);
   assign q.wfull  = (wptr[aw] != rptr[aw]) && (wptr[aw-1:0] == rptr[aw-1:0]);
   assign q.rdata  = mem[rptr[aw-1:0]];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wptr <= '0;
         rptr <= '0;
      end else begin
         if (q.winc) begin
            wptr <= wptr + 1'b1;
         end
         if (q.rinc) begin
            rptr <= rptr + 1'b1;
         end
      end
   end

   // storage only
   always_ff @(posedge clk) begin
      if (q.winc) begin
         mem[wptr[aw-1:0]] <= q.wdata;
      end
   end

endmodule

`default_nettype wire

//--- rtl/cmd_sequencer.sv
`default_nettype none
`timescale 1ns/100ps

// fetch, decode and run host commands
module cmd_sequencer (
   input wire          clk,
   input wire          arst_n,
   fifo_port_if.reader rx,
   fifo_port_if.writer tx,
   output logic        adc_sample,
   output logic [2:0]  adc_channel,
   input wire          adc_busy,
   input wire [9:0]    adc_result,
   output logic        shutter_open,
   output logic        peltier_on,
   output logic [7:0]  peltier_1_duty,
   output logic [7:0]  peltier_2_duty
);

   import sensor_bridge_pkg::*;

   seq_state_e state;
   cmd_e       opcode;     // holding register
   logic [7:0] arg;
   logic       busy_seen;  // reader has taken the sample

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state          <= seq_idle;
         shutter_open   <= 1'b0;  // closed
         peltier_on     <= 1'b0;
         peltier_1_duty <= '0;
         peltier_2_duty <= '0;
         adc_channel    <= '0;
         busy_seen      <= 1'b0;
      end else begin
         unique case (state)
            seq_idle: begin
               if (!rx.rempty) begin
                  state <= seq_fetch;
               end
            end
            seq_fetch: state <= seq_decode;
            seq_decode: begin
               state <= seq_idle;
               case (opcode)
                  cmd_shutter_open:  shutter_open <= 1'b1;
                  cmd_shutter_close: shutter_open <= 1'b0;
                  cmd_peltier_on:    peltier_on <= 1'b1;
                  cmd_peltier_off:   peltier_on <= 1'b0;
                  cmd_adc_read, cmd_peltier_1_set, cmd_peltier_2_set: begin
                     state <= seq_arg_wait;
                  end
                  default: state <= seq_idle;  // unknown opcode is dropped
               endcase
            end
            seq_arg_wait: begin
               if (!rx.rempty) begin
                  state <= seq_arg_apply;
               end
            end
            seq_arg_apply: begin
               state <= seq_idle;
               case (opcode)
                  cmd_adc_read: begin
                     adc_channel <= arg[2:0];
                     state       <= seq_adc_start;
                  end
                  cmd_peltier_1_set: peltier_1_duty <= arg;
                  cmd_peltier_2_set: peltier_2_duty <= arg;
                  default: state <= seq_idle;
               endcase
            end
            seq_adc_start: begin
               busy_seen <= 1'b0;
               state     <= seq_adc_wait;
            end
            seq_adc_wait: begin
               if (adc_busy) begin
                  busy_seen <= 1'b1;
               end else if (busy_seen) begin
                  state <= seq_tx_low;  // conversion finished
               end
            end
            seq_tx_low: begin
               if (!tx.wfull) begin
                  state <= seq_tx_high;
               end
            end
            seq_tx_high: begin
               if (!tx.wfull) begin
                  state <= seq_idle;
               end
            end
            default: state <= seq_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == seq_fetch) begin
         opcode <= cmd_e'(rx.rdata);
      end
      if (state == seq_arg_wait && !rx.rempty) begin
         arg <= rx.rdata;
      end
   end

   assign rx.rinc     = (state == seq_fetch) || (state == seq_arg_wait && !rx.rempty);
   assign adc_sample  = (state == seq_adc_start);

   // result low byte first, then the two msbs
   assign tx.winc  = (state == seq_tx_low || state == seq_tx_high) && !tx.wfull;
   assign tx.wdata = (state == seq_tx_high) ? {6'b0, adc_result[9:8]} : adc_result[7:0];

endmodule

`default_nettype wire

//--- rtl/fifo_port_if.sv
`default_nettype none
`timescale 1ns/100ps

// both ends of one byte FIFO
interface fifo_port_if;
   logic [7:0] wdata;
   logic       winc;
   logic       wfull;
   logic [7:0] rdata;
   logic       rinc;
   logic       rempty;

   modport writer (output wdata, output winc, input wfull);
   modport reader (input rdata, input rempty, output rinc);
   modport storage (
      input  wdata, input  winc, output wfull,
      output rdata, input  rinc, output rempty
   );
endinterface

`default_nettype wire

//--- rtl/ft245_port.sv
`default_nettype none
`timescale 1ns/100ps

// single byte read and write cycles on a synchronous FT245 bus
module ft245_port (
   input wire          clk,
   input wire          arst_n,
   input wire [7:0]    ft_data_in,
   input wire          ft_rxf_n,
   input wire          ft_txe_n,
   output logic [7:0]  ft_data_out,
   output logic        ft_data_oe,
   output logic        ft_rd_n,
   output logic        ft_wr_n,
   output logic        ft_oe_n,
   fifo_port_if.writer rx,
   fifo_port_if.reader tx
);

   import sensor_bridge_pkg::*;

   ft_state_e state;
   logic      wr_prio;  // set after a read so the next turn goes to tx
   logic      rd_ready;
   logic      wr_ready;

   assign rd_ready = !ft_rxf_n && !rx.wfull;
   assign wr_ready = !ft_txe_n && !tx.rempty;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= ft_idle;
         wr_prio <= 1'b0;
      end else begin
         unique case (state)
            ft_idle: begin
               if (wr_ready && (wr_prio || !rd_ready)) begin
                  state <= ft_write;
               end else if (rd_ready) begin
                  state <= ft_oe;
               end
            end
            ft_oe: state <= ft_read;  // bus turnaround
            ft_read: begin
               state   <= ft_idle;
               wr_prio <= 1'b1;
            end
            ft_write: begin
               state   <= ft_idle;  // unsent byte stays at the tx head
               wr_prio <= 1'b0;
            end
         endcase
      end
   end

   // oe_n stays low through the rd_n cycle so the host keeps driving
   assign ft_oe_n     = !(state == ft_oe || state == ft_read);
   assign ft_rd_n     = (state != ft_read);
   assign ft_wr_n     = (state != ft_write);
   assign ft_data_oe  = (state == ft_write);
   assign ft_data_out = tx.rdata;

   assign rx.wdata = ft_data_in;
   assign rx.winc  = (state == ft_read) && !ft_rxf_n;
   assign tx.rinc  = (state == ft_write) && !ft_txe_n;  // host took it

endmodule

`default_nettype wire

//--- rtl/mcp3008_reader.sv
`default_nettype none
`timescale 1ns/100ps
`include "sensor_bridge_settings.svh"

// one single-ended MCP3008 conversion over SPI mode 0,0
module mcp3008_reader (
   input wire         clk,
   input wire         arst_n,
   input wire         sample,
   input wire [2:0]   channel,
   input wire         dout,
   output logic       dclk,
   output logic       din,
   output logic       cs_n,
   output logic       busy,
   output logic [9:0] result
);

   import sensor_bridge_pkg::*;

   localparam int div_w = $clog2(`ADC_DCLK_DIV + 1);

   adc_state_e       state;
   logic [div_w-1:0] div_cnt;
   logic [4:0]       bit_cnt;  // dclk period 0..16
   logic [4:0]       cmd_sr;   // start, sgl, d2..d0
   logic [9:0]       data_sr;
   logic             half_done;

   assign half_done = (div_cnt == div_w'(`ADC_DCLK_DIV - 1));
   assign din       = cmd_sr[4];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= adc_idle;
         div_cnt <= '0;
         bit_cnt <= '0;
         cmd_sr  <= '0;
         dclk    <= 1'b0;
         cs_n    <= 1'b1;
         busy    <= 1'b0;
      end else begin
         unique case (state)
            adc_idle: begin
               if (sample) begin
                  state   <= adc_shift;
                  cs_n    <= 1'b0;
                  busy    <= 1'b1;
                  div_cnt <= '0;
                  bit_cnt <= '0;
                  cmd_sr  <= {2'b11, channel};
               end
            end
            adc_shift: begin
               div_cnt <= half_done ? '0 : div_cnt + 1'b1;
               if (half_done) begin
                  dclk <= !dclk;
                  if (dclk) begin  // falling edge shifts the next din bit
                     cmd_sr  <= {cmd_sr[3:0], 1'b0};
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == 5'd16) begin
                        state <= adc_done;
                     end
                  end
               end
            end
            adc_done: begin
               cs_n  <= 1'b1;
               busy  <= 1'b0;
               state <= adc_idle;
            end
            default: state <= adc_idle;
         endcase
      end
   end

   // periods 5 and 6 carry sample and null bit and b9..b0 follow
   always_ff @(posedge clk) begin
      if (state == adc_shift && half_done && !dclk && bit_cnt >= 5'd7) begin
         data_sr <= {data_sr[8:0], dout};
      end
      if (state == adc_done) begin
         result <= data_sr;
      end
   end

endmodule

`default_nettype wire

//--- rtl/pwm_bank.sv
`default_nettype none
`timescale 1ns/100ps
`include "sensor_bridge_settings.svh"

// shutter servo and peltier PWMs off one shared count
module pwm_bank (
   input wire       clk,
   input wire       arst_n,
   input wire       shutter_open,
   input wire       peltier_on,
   input wire [7:0] peltier_1_duty,
   input wire [7:0] peltier_2_duty,
   output logic     pwm_shutter,
   output logic     pwm_peltier_1,
   output logic     pwm_peltier_2
);

   localparam int pre_w   = $clog2(`PWM_PRESCALE + 1);
   localparam int frame_w = $clog2(`SHUTTER_FRAME_PERIODS + 1);

   logic [pre_w-1:0]   pre_cnt;
   logic [7:0]         count;
   logic [frame_w-1:0] frame_cnt;   // count wraps within the shutter frame
   logic               tick;
   logic [7:0]         shutter_duty;

   assign tick         = (pre_cnt == pre_w'(`PWM_PRESCALE - 1));
   assign shutter_duty = shutter_open ? 8'(`SHUTTER_OPEN_DUTY) : 8'(`SHUTTER_CLOSED_DUTY);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pre_cnt       <= '0;
         count         <= '0;
         frame_cnt     <= '0;
         pwm_shutter   <= 1'b0;
         pwm_peltier_1 <= 1'b0;
         pwm_peltier_2 <= 1'b0;
      end else begin
         pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
         if (tick) begin
            count <= count + 1'b1;
            if (count == 8'hff) begin
               frame_cnt <= (frame_cnt == frame_w'(`SHUTTER_FRAME_PERIODS - 1)) ?
                            '0 : frame_cnt + 1'b1;
            end
         end
         pwm_shutter   <= (frame_cnt == '0) && (count <= shutter_duty);
         pwm_peltier_1 <= peltier_on && (count < peltier_1_duty);
         pwm_peltier_2 <= peltier_on && (count < peltier_2_duty);
      end
   end

endmodule

`default_nettype wire

//--- rtl/sensor_bridge.sv
`default_nettype none
`timescale 1ns/100ps
`include "sensor_bridge_settings.svh"

module sensor_bridge (
   input wire         clk,
   input wire         arst_n,
   input wire [7:0]   ft_data_in,
   input wire         ft_rxf_n,
   input wire         ft_txe_n,
   output logic [7:0] ft_data_out,
   output logic       ft_data_oe,  // tristate lives in the pad wrapper
   output logic       ft_rd_n,
   output logic       ft_wr_n,
   output logic       ft_oe_n,
   input wire         mcp_dout,
   output logic       mcp_dclk,
   output logic       mcp_din,
   output logic       mcp_cs_n,
   output logic       pwm_shutter,
   output logic       pwm_peltier_1,
   output logic       pwm_peltier_2
);

   logic       adc_sample;
   logic [2:0] adc_channel;
   logic       adc_busy;
   logic [9:0] adc_result;
   logic       shutter_open;
   logic       peltier_on;
   logic [7:0] peltier_1_duty;
   logic [7:0] peltier_2_duty;

   fifo_port_if rx_q ();  // host -> sequencer
   fifo_port_if tx_q ();  // sequencer -> host

   ft245_port u_ft245 (
      .clk, .arst_n, .ft_data_in, .ft_rxf_n, .ft_txe_n,
      .ft_data_out, .ft_data_oe, .ft_rd_n, .ft_wr_n, .ft_oe_n,
      .rx (rx_q.writer),
      .tx (tx_q.reader)
   );

   byte_fifo #(.depth(`FIFO_DEPTH)) rx_fifo (.clk, .arst_n, .q(rx_q.storage));
   byte_fifo #(.depth(`FIFO_DEPTH)) tx_fifo (.clk, .arst_n, .q(tx_q.storage));

   cmd_sequencer u_seq (
      .clk, .arst_n,
      .rx (rx_q.reader),
      .tx (tx_q.writer),
      .adc_sample, .adc_channel, .adc_busy, .adc_result,
      .shutter_open, .peltier_on, .peltier_1_duty, .peltier_2_duty
   );

   mcp3008_reader u_adc (
      .clk, .arst_n,
      .sample  (adc_sample),
      .channel (adc_channel),
      .dout    (mcp_dout),
      .dclk    (mcp_dclk),
      .din     (mcp_din),
      .cs_n    (mcp_cs_n),
      .busy    (adc_busy),
      .result  (adc_result)
   );

   pwm_bank u_pwm (
      .clk, .arst_n, .shutter_open, .peltier_on, .peltier_1_duty, .peltier_2_duty,
      .pwm_shutter, .pwm_peltier_1, .pwm_peltier_2
   );

endmodule

`default_nettype wire

//--- rtl/sensor_bridge_pkg.sv
`default_nettype none

package sensor_bridge_pkg;

   // host command opcodes
   typedef enum logic [7:0] {
      cmd_adc_read      = 8'd1, // + channel byte
      cmd_shutter_open  = 8'd2,
      cmd_shutter_close = 8'd3,
      cmd_peltier_on    = 8'd4,
      cmd_peltier_off   = 8'd5,
      cmd_peltier_1_set = 8'd6, // + duty byte
      cmd_peltier_2_set = 8'd7  // + duty byte
   } cmd_e;

   typedef enum logic [3:0] {
      seq_idle,
      seq_fetch,
      seq_decode,
      seq_arg_wait,
      seq_arg_apply,
      seq_adc_start,
      seq_adc_wait,
      seq_tx_low,
      seq_tx_high
   } seq_state_e;

   typedef enum logic [1:0] {adc_idle, adc_shift, adc_done} adc_state_e;

   typedef enum logic [1:0] {ft_idle, ft_oe, ft_read, ft_write} ft_state_e;

endpackage

`default_nettype wire

//--- sensor_bridge.f
+incdir+include
rtl/sensor_bridge_pkg.sv
rtl/fifo_port_if.sv
rtl/byte_fifo.sv
rtl/ft245_port.sv
rtl/cmd_sequencer.sv
rtl/mcp3008_reader.sv
rtl/pwm_bank.sv
rtl/sensor_bridge.sv
tb/mcp3008_model.sv
tb/sensor_bridge_tb.sv

//--- tb/mcp3008_model.sv
`default_nettype none
`timescale 1ns/100ps

// behavioral MCP3008 for single-ended conversions only
module mcp3008_model (
   input wire        cs_n,
   input wire        dclk,
   input wire        din,
   input wire [2:0]  exp_channel,
   input logic [9:0] values [8],
   output logic      dout,
   output int        cmd_errors
);

   logic [4:0] cmd;    // start, sgl, d2..d0 as clocked in
   logic [9:0] value;
   logic [3:0] idx;
   int         rises;  // rising dclk edges seen in this frame

   initial begin
      dout       = 1'b0;
      cmd_errors = 0;
      forever begin
         @(negedge cs_n);
         rises = 0;
         cmd   = '0;
         value = '0;
         dout  = 1'b0;
         while (!cs_n) begin
            @(posedge dclk or posedge cs_n);
            if (!cs_n) begin
               if (rises < 5) begin
                  cmd = {cmd[3:0], din};
               end
               rises++;
               if (rises == 5) begin
                  value = values[cmd[2:0]];
                  assert (cmd == {2'b11, exp_channel})
                  else begin
                     cmd_errors++;
                     $display("ERROR adc_command: expected %b, actual %b",
                              {2'b11, exp_channel}, cmd);
                  end
               end
               @(negedge dclk or posedge cs_n);
               // null bit first, then b9 down to b0
               idx  = 4'(16 - rises);
               dout = (rises >= 7 && rises <= 16) ? value[idx] : 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- tb/sensor_bridge_tb.sv
`default_nettype none
`timescale 1ns/100ps
`include "sensor_bridge_settings.svh"

module sensor_bridge_tb;

   import sensor_bridge_pkg::*;

   localparam int pwm_period    = 256 * `PWM_PRESCALE;
   localparam int shutter_frame = pwm_period * `SHUTTER_FRAME_PERIODS;

   logic       clk        = 1'b0;
   logic       arst_n     = 1'b0;
   logic [7:0] ft_data_in = 8'h00;
   logic       ft_rxf_n   = 1'b1;
   logic       ft_txe_n   = 1'b1;
   logic       mcp_dout;
   logic [7:0] ft_data_out;
   logic       ft_data_oe;
   logic       ft_rd_n;
   logic       ft_wr_n;
   logic       ft_oe_n;
   logic       mcp_dclk;
   logic       mcp_din;
   logic       mcp_cs_n;
   logic       pwm_shutter;
   logic       pwm_peltier_1;
   logic       pwm_peltier_2;

   logic [7:0] send_q [$];      // bytes the host offers
   int         send_idx = 0;
   logic [7:0] recv_q [$];      // bytes the host accepted
   int         recv_idx = 0;
   int         wr_strobes = 0;  // cycles with ft_wr_n low
   logic       host_txe_n = 1'b0;
   logic [2:0] adc_ch_q [$];    // channel of each expected conversion
   int         adc_ch_idx = 0;
   logic [2:0] adc_exp_ch = '0;
   logic [9:0] adc_vals [8];
   int         conv_done = 0;
   int         stray_convs = 0;
   int         adc_cmd_errors;
   int         errors = 0;
   bit         timed_out = 1'b0;

   sensor_bridge dut (
      .clk, .arst_n, .ft_data_in, .ft_rxf_n, .ft_txe_n,
      .ft_data_out, .ft_data_oe, .ft_rd_n, .ft_wr_n, .ft_oe_n,
      .mcp_dout, .mcp_dclk, .mcp_din, .mcp_cs_n,
      .pwm_shutter, .pwm_peltier_1, .pwm_peltier_2
   );

   mcp3008_model adc_model (
      .cs_n (mcp_cs_n), .dclk (mcp_dclk), .din (mcp_din), .exp_channel (adc_exp_ch),
      .values (adc_vals), .dout (mcp_dout), .cmd_errors (adc_cmd_errors)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   // FT232H side where strobes are stable until the next rising edge
   always @(negedge clk) begin
      ft_txe_n   = host_txe_n;
      ft_rxf_n   = (send_idx >= send_q.size());
      ft_data_in = (!ft_oe_n && !ft_rxf_n) ? send_q[send_idx] : 8'h00;
      if (!ft_rd_n && !ft_rxf_n) begin
         send_idx++;  // taken on the coming edge
      end
      if (!ft_wr_n) begin
         wr_strobes++;
         expect_eq("write_data_oe", 1, int'(ft_data_oe));
      end
      if (!ft_wr_n && !ft_txe_n) begin
         recv_q.push_back(ft_data_out);
      end
   end

   always @(negedge mcp_cs_n) begin
      if (adc_ch_idx < adc_ch_q.size()) begin
         adc_exp_ch = adc_ch_q[adc_ch_idx];
         adc_ch_idx++;
      end else begin
         stray_convs++;
         $display("An ADC conversion started with no read command pending");
      end
   end

   always @(posedge mcp_cs_n) conv_done++;

   task automatic expect_eq(input string name, input int expected, input int actual);
      if (!timed_out) begin
         assert (actual == expected)
         else begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
         end
      end
   endtask

   task automatic report_timeout(input string what);
      timed_out = 1'b1;
      $display("Timeout while waiting for %s", what);
   endtask

   task automatic send_byte(input logic [7:0] b);
      @(posedge clk);
      send_q.push_back(b);
   endtask

   task automatic wait_sent();
      int t;
      t = 0;
      while (!timed_out && send_idx < send_q.size()) begin
         @(negedge clk);
         t++;
         if (t > 2000) report_timeout("the DUT to read the host bytes");
      end
   endtask

   task automatic wait_bytes(input int n, input string what);
      int t;
      t = 0;
      while (!timed_out && recv_q.size() - recv_idx < n) begin
         @(negedge clk);
         t++;
         if (t > 4000) report_timeout({"reply bytes of ", what});
      end
   endtask

   task automatic wait_conversions(input int target);
      int t;
      t = 0;
      while (!timed_out && conv_done < target) begin
         @(negedge clk);
         t++;
         if (t > 8000) report_timeout("the ADC conversions to finish");
      end
   endtask

   task automatic wait_shutter(input logic level, output int cycles);
      int t;
      t = 0;
      while (!timed_out && pwm_shutter != level) begin
         @(negedge clk);
         t++;
         if (t > 3 * shutter_frame) report_timeout("a shutter pulse edge");
      end
      cycles = t;
   endtask

   // the sequencer may still be working through earlier bytes
   task automatic settle();
      wait_sent();
      repeat (16) @(negedge clk);
   endtask

   task automatic check_idle(input string name);
      expect_eq({name, "_rd_n"}, 1, int'(ft_rd_n));
      expect_eq({name, "_wr_n"}, 1, int'(ft_wr_n));
      expect_eq({name, "_oe_n"}, 1, int'(ft_oe_n));
      expect_eq({name, "_cs_n"}, 1, int'(mcp_cs_n));
      expect_eq({name, "_data_oe"}, 0, int'(ft_data_oe));
      expect_eq({name, "_dclk"}, 0, int'(mcp_dclk));
   endtask

   task automatic expect_reply(input string name, input logic [9:0] value);
      wait_bytes(2, name);
      if (!timed_out) begin
         expect_eq({name, "_low"}, int'(value[7:0]), int'(recv_q[recv_idx]));
         expect_eq({name, "_high"}, int'(value[9:8]), int'(recv_q[recv_idx + 1]));
         recv_idx += 2;
      end
   endtask

   task automatic expect_quiet(input string name);
      repeat (32) @(negedge clk);
      expect_eq(name, 0, recv_q.size() - recv_idx);
   endtask

   task automatic measure_peltier(input string name, input int exp_1, input int exp_2);
      int high_1;
      int high_2;
      high_1 = 0;
      high_2 = 0;
      repeat (pwm_period) begin
         @(negedge clk);
         if (pwm_peltier_1) high_1++;
         if (pwm_peltier_2) high_2++;
      end
      expect_eq({name, "_1"}, exp_1, high_1);
      expect_eq({name, "_2"}, exp_2, high_2);
   endtask

   task automatic measure_shutter(input string name, input int exp_width);
      int skip;
      int high_len;
      int low_len;
      wait_shutter(1'b0, skip);
      wait_shutter(1'b1, skip);  // align to a fresh rising edge
      wait_shutter(1'b0, high_len);
      wait_shutter(1'b1, low_len);
      expect_eq({name, "_width"}, exp_width, high_len);
      expect_eq({name, "_period"}, shutter_frame, high_len + low_len);
   endtask

   initial begin
      int         seed_dummy;
      logic [7:0] duty_1;
      logic [7:0] duty_2;
      logic [2:0] ch;
      logic [9:0] held_vals [6];
      int         conv_start;
      int         strobe_start;

      seed_dummy = $urandom(73746);
      foreach (adc_vals[i]) adc_vals[i] = 10'($urandom);

      repeat (16) begin
         @(negedge clk);
         check_idle("reset");
      end
      arst_n = 1'b1;
      measure_peltier("reset_peltier", 0, 0);
      check_idle("after_reset");

      for (int c = 0; c < 8; c++) begin
         adc_ch_q.push_back(3'(c));
         send_byte(cmd_adc_read);
         send_byte(8'(c));
         expect_reply($sformatf("adc_ch%0d", c), adc_vals[c]);
         expect_quiet($sformatf("adc_ch%0d_extra", c));
      end

      duty_1 = 8'($urandom);
      duty_2 = 8'($urandom);
      send_byte(cmd_peltier_1_set);
      send_byte(duty_1);
      send_byte(cmd_peltier_2_set);
      send_byte(duty_2);
      send_byte(cmd_peltier_on);
      settle();
      measure_peltier("peltier_duty", int'(duty_1) * `PWM_PRESCALE,
                      int'(duty_2) * `PWM_PRESCALE);
      send_byte(cmd_peltier_off);
      settle();
      measure_peltier("peltier_off", 0, 0);

      send_byte(cmd_shutter_open);
      settle();
      measure_shutter("shutter_open", (`SHUTTER_OPEN_DUTY + 1) * `PWM_PRESCALE);
      send_byte(cmd_shutter_close);
      settle();
      measure_shutter("shutter_closed", (`SHUTTER_CLOSED_DUTY + 1) * `PWM_PRESCALE);

      // host stops taking bytes so replies pile up in tx_q
      @(posedge clk);
      host_txe_n   = 1'b1;
      strobe_start = wr_strobes;
      conv_start   = conv_done;
      for (int i = 0; i < 6; i++) begin
         ch           = 3'($urandom);
         held_vals[i] = adc_vals[ch];
         adc_ch_q.push_back(ch);
         send_byte(8'(8'hf0 + i));  // unknown opcode
         send_byte(cmd_adc_read);
         send_byte({5'd0, ch});
      end
      wait_conversions(conv_start + 6);
      repeat (16) @(negedge clk);
      expect_eq("held_strobes", 0, wr_strobes - strobe_start);
      @(posedge clk);
      host_txe_n = 1'b0;
      for (int i = 0; i < 6; i++) begin
         expect_reply($sformatf("held_read%0d", i), held_vals[i]);
      end
      expect_quiet("held_extra");

      $display("failed checks: %0d, adc command errors: %0d, stray conversions: %0d, timeouts: %0d",
               errors, adc_cmd_errors, stray_convs, int'(timed_out));
      if (errors == 0 && adc_cmd_errors == 0 && stray_convs == 0 && !timed_out) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire
